// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_proc
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard hw/*.sv hw/*.svh bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation FAILED, no result in $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/proc_tests.svh ====
`ifndef PROC_TESTS_SVH
`define PROC_TESTS_SVH

function automatic word_t r_type(input alu_op_e op, input int rd, input int rs, input int rt,
                                 input int shamt);
    return {op_alu, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], op, 2'b00};
endfunction

function automatic word_t i_type(input opcode_e op, input int rd, input int rs, input int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic word_t j_type(input opcode_e op, input int target);
    return {op, target[26:0]};
endfunction

// Copies prog into instruction memory, the rest becomes no-ops
task automatic load_program();
    for (int i = 0; i < 256; i++) begin
        imem[i[7:0]] = (i < prog.size()) ? prog[i] : '0;
        dmem[i[7:0]] <= dmem_fill(i);
    end
    for (int i = 0; i < 32; i++) begin
        regs[i[4:0]] <= '0;
    end
endtask

task automatic verify_reg(input string name, input int idx, input word_t expected);
    compare_word($sformatf("%s r%0d", name, idx), expected, regs[idx[4:0]]);
endtask

task automatic verify_mem(input string name, input int addr, input word_t expected);
    compare_word($sformatf("%s dmem[%0d]", name, addr), expected, dmem[addr[7:0]]);
endtask

task automatic reset_state();
    prog.delete();
    for (int i = 0; i < 8; i++) begin
        prog.push_back(i_type(op_sw, 0, 0, i));
        prog.push_back(i_type(op_addi, i + 1, 0, i + 1));
    end
    load_program();
    apply_reset("reset_state");
    for (int k = 0; k < reset_budget; k++) begin
        compare_word("reset_state address_imem", `PROC_RESET_PC + word_t'(k), address_imem);
        @(negedge clock);
    end
    apply_reset("reset_state");    // A store and a register write are in flight here
endtask

task automatic alu_forwarding();
    prog.delete();
    prog.push_back(i_type(op_addi, 1, 0, 5));
    prog.push_back(i_type(op_addi, 2, 1, -3));
    prog.push_back(r_type(alu_add, 3, 2, 1, 0));     // r1 from writeback
    prog.push_back(r_type(alu_sub, 4, 1, 3, 0));     // r1 through the write-through
    prog.push_back(r_type(alu_and, 5, 4, 3, 0));
    prog.push_back(r_type(alu_or, 6, 5, 1, 0));
    prog.push_back(r_type(alu_sll, 7, 6, 0, 4));
    prog.push_back(r_type(alu_sub, 8, 0, 7, 0));
    prog.push_back(r_type(alu_sra, 9, 8, 0, 2));
    prog.push_back(r_type(alu_add, 10, 9, 9, 0));
    load_program();
    apply_reset("alu_forwarding");
    repeat (alu_budget) @(negedge clock);
    verify_reg("alu_forwarding", 1, 32'd5);
    verify_reg("alu_forwarding", 2, 32'd2);
    verify_reg("alu_forwarding", 3, 32'd7);
    verify_reg("alu_forwarding", 4, 32'hffff_fffe);    // 5 - 7
    verify_reg("alu_forwarding", 5, 32'd6);
    verify_reg("alu_forwarding", 6, 32'd7);
    verify_reg("alu_forwarding", 7, 32'h70);
    verify_reg("alu_forwarding", 8, 32'hffff_ff90);
    verify_reg("alu_forwarding", 9, 32'hffff_ffe4);    // -112 / 4
    verify_reg("alu_forwarding", 10, 32'hffff_ffc8);
endtask

task automatic memory_load_use();
    prog.delete();
    prog.push_back(i_type(op_addi, 1, 0, 20));
    prog.push_back(i_type(op_addi, 2, 0, 32'h1234));
    prog.push_back(i_type(op_sw, 2, 1, 4));
    prog.push_back(i_type(op_lw, 3, 1, 4));
    prog.push_back(r_type(alu_add, 4, 3, 1, 0));     // Load-use stall
    prog.push_back(i_type(op_sw, 4, 1, 8));
    prog.push_back(i_type(op_lw, 5, 1, -1));         // Word never stored
    prog.push_back(r_type(alu_add, 6, 5, 5, 0));
    prog.push_back(i_type(op_lw, 7, 1, 8));
    prog.push_back(i_type(op_sw, 7, 1, 12));         // Store data straight from a load
    load_program();
    apply_reset("memory_load_use");
    repeat (mem_budget) @(negedge clock);
    verify_mem("memory_load_use", 24, 32'h1234);
    verify_mem("memory_load_use", 28, 32'h1248);
    verify_mem("memory_load_use", 32, 32'h1248);
    verify_reg("memory_load_use", 3, 32'h1234);
    verify_reg("memory_load_use", 4, 32'h1248);
    verify_reg("memory_load_use", 5, dmem_fill(19));
    verify_reg("memory_load_use", 6, dmem_fill(19) + dmem_fill(19));
    verify_reg("memory_load_use", 7, 32'h1248);
endtask

task automatic branch_paths();
    prog.delete();
    prog.push_back(i_type(op_addi, 1, 0, 3));
    prog.push_back(i_type(op_addi, 2, 0, 7));
    prog.push_back(i_type(op_bne, 1, 2, 2));         // Taken, to 5
    prog.push_back(i_type(op_addi, 10, 0, 1));
    prog.push_back(i_type(op_addi, 11, 0, 1));
    prog.push_back(i_type(op_addi, 12, 0, 12));
    prog.push_back(i_type(op_bne, 1, 1, 2));         // Not taken
    prog.push_back(i_type(op_addi, 13, 0, 13));
    prog.push_back(i_type(op_blt, 1, 2, 2));         // 3 below 7, to 11
    prog.push_back(i_type(op_addi, 15, 0, 1));
    prog.push_back(i_type(op_addi, 16, 0, 1));
    prog.push_back(i_type(op_addi, 17, 0, 17));
    prog.push_back(i_type(op_blt, 2, 1, 2));         // Not taken
    prog.push_back(i_type(op_addi, 18, 0, 18));
    load_program();
    apply_reset("branch_paths");
    repeat (branch_budget) @(negedge clock);
    verify_reg("branch_paths", 10, '0);
    verify_reg("branch_paths", 11, '0);
    verify_reg("branch_paths", 12, 32'd12);
    verify_reg("branch_paths", 13, 32'd13);
    verify_reg("branch_paths", 15, '0);
    verify_reg("branch_paths", 16, '0);
    verify_reg("branch_paths", 17, 32'd17);
    verify_reg("branch_paths", 18, 32'd18);
endtask

task automatic jump_and_link();
    prog.delete();
    prog.push_back(i_type(op_addi, 1, 0, 1));
    prog.push_back(j_type(op_j, 4));
    prog.push_back(i_type(op_addi, 2, 0, 2));
    prog.push_back(i_type(op_addi, 3, 0, 3));
    prog.push_back(j_type(op_jal, 8));               // Link value 5
    prog.push_back(i_type(op_addi, 4, 0, 4));
    prog.push_back(j_type(op_j, 12));
    prog.push_back(i_type(op_addi, 5, 0, 5));
    prog.push_back(i_type(op_addi, 6, 0, 6));        // Subroutine body
    prog.push_back(i_type(op_jr, 31, 0, 0));
    prog.push_back(i_type(op_addi, 7, 0, 7));
    prog.push_back(i_type(op_addi, 8, 0, 8));
    prog.push_back(i_type(op_addi, 9, 0, 9));
    load_program();
    apply_reset("jump_and_link");
    repeat (jump_budget) @(negedge clock);
    verify_reg("jump_and_link", 1, 32'd1);
    verify_reg("jump_and_link", 2, '0);
    verify_reg("jump_and_link", 3, '0);
    verify_reg("jump_and_link", int'(`PROC_LINK_REG), 32'd5);
    verify_reg("jump_and_link", 4, 32'd4);
    verify_reg("jump_and_link", 5, '0);
    verify_reg("jump_and_link", 6, 32'd6);
    verify_reg("jump_and_link", 7, '0);
    verify_reg("jump_and_link", 8, '0);
    verify_reg("jump_and_link", 9, 32'd9);
endtask

task automatic random_chain();
    word_t       model [8];
    logic [16:0] imm_bits;
    int          rd;
    int          rs;
    int          rt;
    prog.delete();
    for (int i = 0; i < 8; i++) begin
        model[i[2:0]] = '0;
    end
    for (int n = 0; n < 20; n++) begin
        rd = 1 + int'($urandom % 7);    // r1..r7, r0 stays zero
        rs = int'($urandom % 8);
        if ($urandom % 2 == 0) begin
            imm_bits = 17'($urandom);
            prog.push_back(i_type(op_addi, rd, rs, int'(imm_bits)));
            model[rd[2:0]] = model[rs[2:0]] + {{15{imm_bits[16]}}, imm_bits};
        end else begin
            rt = int'($urandom % 8);
            prog.push_back(r_type(alu_add, rd, rs, rt, 0));
            model[rd[2:0]] = model[rs[2:0]] + model[rt[2:0]];
        end
    end
    load_program();
    apply_reset("random_chain");
    repeat (random_budget) @(negedge clock);
    for (int i = 1; i < 8; i++) begin
        verify_reg("random_chain", i, model[i[2:0]]);
    end
endtask

`endif

// ==== bench/tb_proc.sv ====
`timescale 1ns/1ps
`include "proc_cfg.svh"

module tb_proc;
    import proc_pkg::*;

    localparam int clock_period  = 8;
    localparam int reset_cycles  = 16;
    localparam int random_seed   = 76964;
    // Cycles each test runs after reset is released
    localparam int reset_budget  = 4;
    localparam int alu_budget    = 20;
    localparam int mem_budget    = 24;
    localparam int branch_budget = 30;
    localparam int jump_budget   = 32;
    localparam int random_budget = 32;
    localparam int total_cycles  = 7 * reset_cycles + reset_budget + alu_budget + mem_budget
                                   + branch_budget + jump_budget + random_budget;
    localparam int watchdog_ns   = total_cycles * clock_period * 2;

    logic     clock;
    logic     reset;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    word_t imem [256];
    word_t dmem [256];
    word_t regs [32];
    word_t prog [$];             // Program of the running test
    int    check_count;
    int    error_count;

    proc_core u_proc_core (
        .clock (clock), .reset (reset),
        .address_imem (address_imem), .q_imem (q_imem),
        .address_dmem (address_dmem), .data (data), .wren (wren), .q_dmem (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable), .ctrl_writeReg (ctrl_writeReg),
        .ctrl_readRegA (ctrl_readRegA), .ctrl_readRegB (ctrl_readRegB),
        .data_writeReg (data_writeReg),
        .data_readRegA (data_readRegA), .data_readRegB (data_readRegB)
    );

    // Memories and register file answer in the same cycle
    assign q_imem        = imem[address_imem[7:0]];
    assign q_dmem        = dmem[address_dmem[7:0]];
    assign data_readRegA = (ctrl_readRegA == '0) ? '0 : regs[ctrl_readRegA];
    assign data_readRegB = (ctrl_readRegB == '0) ? '0 : regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_writeEnable && ctrl_writeReg != '0) begin
            regs[ctrl_writeReg] <= data_writeReg;
        end
    end

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    function automatic word_t dmem_fill(input int addr);
        return 32'hd000_0000 + word_t'(addr);   // Unwritten words still differ
    endfunction

    task automatic compare_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERR %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic apply_reset(input string name);
        reset = 1'b1;
        repeat (reset_cycles) begin
            @(negedge clock);
            compare_word({name, " wren in reset"}, '0, word_t'(wren));
            compare_word({name, " ctrl_writeEnable in reset"}, '0, word_t'(ctrl_writeEnable));
        end
        reset = 1'b0;
    endtask

    `include "proc_tests.svh"

    initial begin
        reset       = 1'b1;
        check_count = 0;
        error_count = 0;
        void'($urandom(random_seed));
        reset_state();
        alu_forwarding();
        memory_load_use();
        branch_paths();
        jump_and_link();
        random_chain();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== hw/proc_alu.sv ====
`timescale 1ns/1ps

module proc_alu (
    input  proc_pkg::word_t   a,
    input  proc_pkg::word_t   b,
    input  proc_pkg::alu_op_e op,
    input  logic [4:0]        shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = $signed(a) >>> shamt;   // Sign bit fills from the left
            default: result = '0;
        endcase
    end

    // Flags for branches, independent of op
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

// ==== hw/proc_cfg.svh ====
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data word and address width
`define PROC_XLEN        32

// Register number width, 32 registers
`define PROC_REG_BITS    5

`define PROC_IMM_BITS    17   // Sign-extended immediate field
`define PROC_TARGET_BITS 27   // Zero-extended jump target field

// Destination of jal
`define PROC_LINK_REG    5'd31

`define PROC_RESET_PC    32'h0000_0000

`endif

// ==== hw/proc_core.sv ====
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_core (
    input  logic                      clock,
    input  logic                      reset,
    output proc_pkg::word_t           address_imem,
    input  proc_pkg::word_t           q_imem,
    output proc_pkg::word_t           address_dmem,
    output proc_pkg::word_t           data,
    output logic                      wren,
    input  proc_pkg::word_t           q_dmem,
    output logic                      ctrl_writeEnable,
    output logic [`PROC_REG_BITS-1:0] ctrl_writeReg,
    output logic [`PROC_REG_BITS-1:0] ctrl_readRegA,
    output logic [`PROC_REG_BITS-1:0] ctrl_readRegB,
    output proc_pkg::word_t           data_writeReg,
    input  proc_pkg::word_t           data_readRegA,
    input  proc_pkg::word_t           data_readRegB
);
    import proc_pkg::*;

    word_t    fd_inst;
    word_t    fd_pc_plus_one;
    word_t    redirect_pc;
    word_t    wb_value;
    reg_idx_t wb_dest;
    logic     redirect;
    logic     stall;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    de_bus_if de_bus ();
    em_bus_if em_bus ();

    proc_fetch u_fetch (
        .clock (clock), .reset (reset), .stall (stall),
        .redirect (redirect), .redirect_pc (redirect_pc), .q_imem (q_imem),
        .address_imem (address_imem), .fd_inst (fd_inst), .fd_pc_plus_one (fd_pc_plus_one)
    );

    // Taken branch also kills the word in decode
    proc_decode u_decode (
        .clock (clock), .reset (reset), .stall (stall), .flush (redirect),
        .fd_inst (fd_inst), .fd_pc_plus_one (fd_pc_plus_one),
        .data_readRegA (data_readRegA), .data_readRegB (data_readRegB),
        .wb_dest (wb_dest), .wb_value (wb_value),
        .ctrl_readRegA (ctrl_readRegA), .ctrl_readRegB (ctrl_readRegB), .de (de_bus)
    );

    proc_execute u_execute (
        .clock (clock), .reset (reset), .stall (stall),
        .fwd_a (fwd_a), .fwd_b (fwd_b), .wb_value (wb_value),
        .de (de_bus), .em (em_bus), .redirect (redirect), .redirect_pc (redirect_pc)
    );

    proc_hazard u_hazard (
        .clock (clock), .reset (reset), .de (de_bus), .em (em_bus), .wb_dest (wb_dest),
        .fwd_a (fwd_a), .fwd_b (fwd_b), .stall (stall)
    );

    proc_mem_wb u_mem_wb (
        .clock (clock), .reset (reset), .q_dmem (q_dmem), .em (em_bus),
        .address_dmem (address_dmem), .data (data), .wren (wren),
        .ctrl_writeEnable (ctrl_writeEnable), .ctrl_writeReg (ctrl_writeReg),
        .data_writeReg (data_writeReg), .wb_dest (wb_dest), .wb_value (wb_value)
    );

endmodule

// ==== hw/proc_decode.sv ====
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_decode (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         flush,
    input  proc_pkg::word_t              fd_inst,
    input  proc_pkg::word_t              fd_pc_plus_one,
    input  proc_pkg::word_t              data_readRegA,
    input  proc_pkg::word_t              data_readRegB,
    input  proc_pkg::reg_idx_t           wb_dest,
    input  proc_pkg::word_t              wb_value,
    output proc_pkg::reg_idx_t           ctrl_readRegA,
    output proc_pkg::reg_idx_t           ctrl_readRegB,
    de_bus_if.decode                     de
);
    import proc_pkg::*;

    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t src_a;
    reg_idx_t src_b;
    reg_idx_t dest;
    logic     rd_on_b;
    word_t    read_a;
    word_t    read_b;

    assign opcode = opcode_e'(fd_inst[31:27]);
    assign rd     = fd_inst[26:22];
    assign rs     = fd_inst[21:17];
    assign rt     = fd_inst[16:12];

    always_comb begin
        rd_on_b = 1'b1;
        src_a   = rs;
        src_b   = rd;
        dest    = '0;
        case (opcode)
            op_alu: begin
                rd_on_b = 1'b0;
                src_b   = rt;
                dest    = rd;
            end
            op_addi: begin
                rd_on_b = 1'b0;
                src_b   = '0;       // rt bits hold the immediate
                dest    = rd;
            end
            op_lw: begin
                src_b = '0;
                dest  = rd;
            end
            op_sw, op_bne, op_blt: ;
            op_jr:  src_a = '0;
            op_jal: begin
                src_a = '0;
                src_b = '0;
                dest  = `PROC_LINK_REG;
            end
            default: begin          // j and unknown opcodes read nothing
                src_a = '0;
                src_b = '0;
            end
        endcase
    end

    assign ctrl_readRegA = rs;
    assign ctrl_readRegB = rd_on_b ? rd : rt;

    // Register file writes at the same edge, so pass the new value through
    assign read_a = (wb_dest != '0 && wb_dest == ctrl_readRegA) ? wb_value : data_readRegA;
    assign read_b = (wb_dest != '0 && wb_dest == ctrl_readRegB) ? wb_value : data_readRegB;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            de.inst  <= '0;
            de.src_a <= '0;
            de.src_b <= '0;
            de.dest  <= '0;
        end else if (!stall) begin
            de.inst  <= fd_inst;
            de.src_a <= src_a;
            de.src_b <= src_b;
            de.dest  <= dest;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            de.pc_plus_one <= fd_pc_plus_one;
            de.op_a        <= read_a;
            de.op_b        <= read_b;
        end else begin
            // Held instruction would lose this value once writeback moves on
            if (wb_dest != '0 && wb_dest == de.src_a) begin
                de.op_a <= wb_value;
            end
            if (wb_dest != '0 && wb_dest == de.src_b) begin
                de.op_b <= wb_value;
            end
        end
    end

endmodule

// ==== hw/proc_execute.sv ====
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_execute (
    input  logic               clock,
    input  logic               reset,
    input  logic               stall,
    input  proc_pkg::fwd_sel_e fwd_a,
    input  proc_pkg::fwd_sel_e fwd_b,
    input  proc_pkg::word_t    wb_value,
    de_bus_if.execute          de,
    em_bus_if.execute          em,
    output logic               redirect,
    output proc_pkg::word_t    redirect_pc
);
    import proc_pkg::*;

    opcode_e opcode;
    alu_op_e alu_op;
    word_t   imm;
    word_t   target;
    word_t   opnd_a;
    word_t   opnd_b;
    word_t   alu_b;
    word_t   alu_result;
    logic    not_equal;
    logic    less_than;
    logic    taken;

    function automatic word_t forward(input fwd_sel_e sel, input word_t reg_value,
                                      input word_t mem_value, input word_t wb_data);
        word_t value;
        case (sel)
            fwd_mem: value = mem_value;
            fwd_wb:  value = wb_data;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    assign opcode = opcode_e'(de.inst[31:27]);
    assign imm    = {{(`PROC_XLEN - `PROC_IMM_BITS){de.inst[`PROC_IMM_BITS-1]}},
                     de.inst[`PROC_IMM_BITS-1:0]};
    assign target = {{(`PROC_XLEN - `PROC_TARGET_BITS){1'b0}},
                     de.inst[`PROC_TARGET_BITS-1:0]};

    assign opnd_a = forward(fwd_a, de.op_a, em.result, wb_value);
    assign opnd_b = forward(fwd_b, de.op_b, em.result, wb_value);

    // Memory address is rs plus immediate through the adder
    assign alu_b  = (opcode == op_addi || opcode == op_lw || opcode == op_sw) ? imm : opnd_b;
    assign alu_op = (opcode == op_alu) ? alu_op_e'(de.inst[6:2]) : alu_add;

    proc_alu u_alu (
        .a         (opnd_a),
        .b         (alu_b),
        .op        (alu_op),
        .shamt     (de.inst[11:7]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    always_comb begin
        taken       = 1'b0;
        redirect_pc = de.pc_plus_one + imm;
        case (opcode)
            op_bne: taken = not_equal;
            op_blt: taken = not_equal && !less_than;   // rd below rs
            op_j, op_jal: begin
                taken       = 1'b1;
                redirect_pc = target;
            end
            op_jr: begin
                taken       = 1'b1;
                redirect_pc = opnd_b;   // Forwarded rd
            end
            default: taken = 1'b0;
        endcase
    end

    // A stalled branch sees its operands again next cycle
    assign redirect = taken && !stall;

    always_ff @(posedge clock) begin
        if (reset || stall) begin
            em.dest     <= '0;   // Bubble into memory stage
            em.is_load  <= 1'b0;
            em.is_store <= 1'b0;
        end else begin
            em.dest     <= de.dest;
            em.is_load  <= (opcode == op_lw);
            em.is_store <= (opcode == op_sw);
        end
    end

    always_ff @(posedge clock) begin
        em.result      <= (opcode == op_jal) ? de.pc_plus_one : alu_result;
        em.store_value <= opnd_b;
    end

endmodule

// ==== hw/proc_fetch.sv ====
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_fetch (
    input  logic            clock,
    input  logic            reset,
    input  logic            stall,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    input  proc_pkg::word_t q_imem,
    output proc_pkg::word_t address_imem,
    output proc_pkg::word_t fd_inst,
    output proc_pkg::word_t fd_pc_plus_one
);
    import proc_pkg::*;

    word_t pc;
    word_t pc_next_seq;

    assign pc_next_seq  = pc + 32'd1;   // Word-addressed instruction memory
    assign address_imem = pc;

    // Redirect wins over stall and kills the word being fetched
    always_ff @(posedge clock) begin
        if (reset) begin
            pc      <= `PROC_RESET_PC;
            fd_inst <= '0;
        end else if (redirect) begin
            pc      <= redirect_pc;
            fd_inst <= '0;
        end else if (!stall) begin
            pc      <= pc_next_seq;
            fd_inst <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_plus_one <= pc_next_seq;
        end
    end

endmodule

// ==== hw/proc_hazard.sv ====
`timescale 1ns/1ps

module proc_hazard (
    input  logic               clock,
    input  logic               reset,
    de_bus_if.monitor          de,
    em_bus_if.monitor          em,
    input  proc_pkg::reg_idx_t wb_dest,
    output proc_pkg::fwd_sel_e fwd_a,
    output proc_pkg::fwd_sel_e fwd_b,
    output logic               stall
);
    import proc_pkg::*;

    // Youngest producer first
    function automatic fwd_sel_e pick_source(input reg_idx_t src, input reg_idx_t mem_dest,
                                             input reg_idx_t wb_reg);
        fwd_sel_e sel;
        sel = fwd_reg;
        if (src != '0 && src == mem_dest) begin
            sel = fwd_mem;
        end else if (src != '0 && src == wb_reg) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(de.src_a, em.dest, wb_dest);
    assign fwd_b = pick_source(de.src_b, em.dest, wb_dest);

    // Load data only exists once the load reaches writeback
    assign stall = em.is_load && em.dest != '0 &&
                   (de.src_a == em.dest || de.src_b == em.dest);

    // The bubble behind a stall can never itself be a load
    stall_single_cycle: assert property (@(posedge clock) disable iff (reset)
        stall |=> !stall)
        else $error("load-use stall lasted more than one cycle");

endmodule

// ==== hw/proc_if.sv ====
`timescale 1ns/1ps

// Decode/execute pipeline register contents
interface de_bus_if;
    import proc_pkg::*;

    word_t    inst;
    word_t    pc_plus_one;
    word_t    op_a;          // Register read for rs
    word_t    op_b;          // Register read for rt or rd
    reg_idx_t src_a;         // Zero when op_a is unused
    reg_idx_t src_b;
    reg_idx_t dest;          // Zero when nothing is written

    modport decode  (output inst, pc_plus_one, op_a, op_b, src_a, src_b, dest);
    modport execute (input inst, pc_plus_one, op_a, op_b, dest);
    modport monitor (input src_a, src_b);
endinterface

// Execute/memory pipeline register contents
interface em_bus_if;
    import proc_pkg::*;

    word_t    result;        // ALU value, address for loads and stores
    word_t    store_value;
    reg_idx_t dest;
    logic     is_load;
    logic     is_store;

    modport execute (output result, store_value, dest, is_load, is_store);
    modport mem     (input result, store_value, dest, is_load, is_store);
    modport monitor (input dest, is_load);
endinterface

// ==== hw/proc_mem_wb.sv ====
`timescale 1ns/1ps

module proc_mem_wb (
    input  logic               clock,
    input  logic               reset,
    input  proc_pkg::word_t    q_dmem,
    em_bus_if.mem              em,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    output logic               ctrl_writeEnable,
    output proc_pkg::reg_idx_t ctrl_writeReg,
    output proc_pkg::word_t    data_writeReg,
    output proc_pkg::reg_idx_t wb_dest,
    output proc_pkg::word_t    wb_value
);
    import proc_pkg::*;

    reg_idx_t mw_dest;
    word_t    mw_value;

    assign address_dmem = em.result;
    assign data         = em.store_value;
    assign wren         = em.is_store;   // Write lands at the end of this cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_dest <= '0;
        end else begin
            mw_dest <= em.dest;
        end
    end

    always_ff @(posedge clock) begin
        mw_value <= em.is_load ? q_dmem : em.result;
    end

    assign ctrl_writeEnable = (mw_dest != '0);
    assign ctrl_writeReg    = mw_dest;
    assign data_writeReg    = mw_value;

    // Also feeds forwarding and the decode write-through
    assign wb_dest  = mw_dest;
    assign wb_value = mw_value;

    // Both stage registers are cleared by the first reset edge
    no_write_in_reset: assert property (@(posedge clock)
        reset ##1 reset |-> !wren && !ctrl_writeEnable)
        else $error("memory or register write while in reset");

endmodule

// ==== hw/proc_pkg.sv ====
`include "proc_cfg.svh"

package proc_pkg;

    typedef logic [`PROC_XLEN-1:0]     word_t;
    typedef logic [`PROC_REG_BITS-1:0] reg_idx_t;

    // Major opcode, instruction bits 31..27
    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_e;

    // ALU function field, bits 6..2 of an R-type word
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,   // Value read in decode
        fwd_mem = 2'd1,   // Result in the memory stage
        fwd_wb  = 2'd2    // Value being written back
    } fwd_sel_e;

endpackage

// ==== vlog.f ====
+incdir+hw
+incdir+bench
hw/proc_pkg.sv
hw/proc_if.sv
hw/proc_alu.sv
hw/proc_fetch.sv
hw/proc_decode.sv
hw/proc_execute.sv
hw/proc_hazard.sv
hw/proc_mem_wb.sv
hw/proc_core.sv
bench/tb_proc.sv
